//--- source/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// PC loaded on reset
`define RV_RESET_PC 64'h0000_0000_8000_0000

// Power-of-two data memory depth in doublewords
`define RV_DMEM_WORDS 256

// Architectural integer registers
`define RV_NREGS 32

`endif

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_eq     = 3'd4,
        alu_ne     = 3'd5,
        alu_pass_b = 3'd6
    } alu_op_t;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [63:0] imm;          // Sign-extended
        alu_op_t     alu_op;
        logic        use_imm;
        logic        reg_wen;
        logic        mem_ren;
        logic        mem_wen;
        logic        is_branch;
        logic        is_jal;
    } dec_t;

endpackage

`default_nettype wire

//--- source/hazard_if.sv
`timescale 1ns/1ps
`default_nettype none

interface hazard_if;
    logic [4:0] id_rs1;
    logic [4:0] id_rs2;
    logic [4:0] ex_rd;
    logic       ex_mem_ren;     // Load in EX
    logic       redirect;       // Taken branch or JAL in EX
    logic       stall_front;
    logic       flush_front;

    modport core_mp (
        output id_rs1,
        output id_rs2,
        output ex_rd,
        output ex_mem_ren,
        output redirect,
        input  stall_front,
        input  flush_front
    );

    modport ctrl_mp (
        input  id_rs1,
        input  id_rs2,
        input  ex_rd,
        input  ex_mem_ren,
        input  redirect,
        output stall_front,
        output flush_front
    );
endinterface

`default_nettype wire

//--- source/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire  [31:0]   instr,
    output rv_pkg::dec_t  dec
);
    import rv_pkg::*;

    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{52{instr[31]}}, instr[31:20]};
    assign imm_s  = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b  = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j  = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec = '0;
        case (opcode_t'(instr[6:0]))
            op_reg: begin
                dec.rs1     = instr[19:15];
                dec.rs2     = instr[24:20];
                dec.rd      = instr[11:7];
                dec.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec.alu_op = alu_add;
                    {7'h20, 3'b000}: dec.alu_op = alu_sub;
                    {7'h00, 3'b111}: dec.alu_op = alu_and;
                    {7'h00, 3'b110}: dec.alu_op = alu_or;
                    default:         dec = '0;
                endcase
            end
            op_imm: begin
                if (funct3 == 3'b000) begin          // ADDI only
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_i;
                    dec.use_imm = 1'b1;
                    dec.reg_wen = 1'b1;
                end
            end
            op_load: begin
                if (funct3 == 3'b011) begin          // LD
                    dec.rs1     = instr[19:15];
                    dec.rd      = instr[11:7];
                    dec.imm     = imm_i;
                    dec.use_imm = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.mem_ren = 1'b1;
                end
            end
            op_store: begin
                if (funct3 == 3'b011) begin          // SD
                    dec.rs1     = instr[19:15];
                    dec.rs2     = instr[24:20];
                    dec.imm     = imm_s;
                    dec.use_imm = 1'b1;
                    dec.mem_wen = 1'b1;
                end
            end
            op_branch: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    dec.rs1       = instr[19:15];
                    dec.rs2       = instr[24:20];
                    dec.imm       = imm_b;
                    dec.is_branch = 1'b1;
                    dec.alu_op    = funct3[0] ? alu_ne : alu_eq;
                end
            end
            op_jal: begin
                dec.rd      = instr[11:7];
                dec.imm     = imm_j;
                dec.use_imm = 1'b1;
                dec.reg_wen = 1'b1;
                dec.is_jal  = 1'b1;
                dec.alu_op  = alu_pass_b;
            end
            default: dec = '0;                       // No-op
        endcase
        // Writes to x0 are dropped here so later stages never see them
        if (dec.rd == 5'd0)
            dec.reg_wen = 1'b0;
        if (!dec.reg_wen)
            dec.rd = 5'd0;
    end

    mem_excl: assert final (!(dec.mem_ren && dec.mem_wen))
        else $error("decoder set both memory enables for %h", instr);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module reg_file (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  ra,
    input  wire  [4:0]  rb,
    input  wire  [4:0]  rw,
    input  wire         wen,
    input  wire  [63:0] wdata,
    output logic [63:0] rdata_a,
    output logic [63:0] rdata_b
);

    logic [63:0] regs [`RV_NREGS];

    // x0 reads zero and a same-cycle write shows on the read side
    function automatic logic [63:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return 64'd0;
        if (wen && addr == rw)
            return wdata;
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= 64'd0;
        end else if (wen && rw != 5'd0) begin
            regs[rw] <= wdata;
        end
    end

    always_comb begin
        rdata_a = read_port(ra);
        rdata_b = read_port(rb);
    end

endmodule

`default_nettype wire

//--- source/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  var rv_pkg::alu_op_t op,
    input  wire  [63:0]         a,
    input  wire  [63:0]         b,
    output logic [63:0]         result
);
    import rv_pkg::*;

    logic equal;

    assign equal = (a == b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            // Branch compares give a single decision bit
            alu_eq:     result = {63'd0, equal};
            alu_ne:     result = {63'd0, !equal};
            alu_pass_b: result = b;
            default:    result = 64'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/data_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module data_sram #(
    parameter int words = `RV_DMEM_WORDS
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         ren,
    input  wire         wen,
    input  wire  [63:0] addr,
    input  wire  [63:0] wdata,
    output logic [63:0] rdata
);

    localparam int idx_w = $clog2(words);

    logic [63:0]      mem [words];
    logic [idx_w-1:0] idx;

    assign idx = addr[idx_w+2:3];          // Wraps at the array depth

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < words; i++)
                mem[i] <= 64'd0;
        end else if (wen) begin
            mem[idx] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ren)
            rdata <= mem[idx];             // Used one cycle later in WB
    end

    aligned_access: assert property (@(posedge clk) disable iff (!rst_n)
        (ren || wen) |-> addr[2:0] == 3'b000)
        else $error("misaligned data access at %h", addr);

endmodule

`default_nettype wire

//--- source/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
    input wire        clk,
    input wire        rst_n,
    hazard_if.ctrl_mp hz
);

    logic rs1_hit;
    logic rs2_hit;
    logic load_use;

    assign rs1_hit  = (hz.ex_rd == hz.id_rs1);
    assign rs2_hit  = (hz.ex_rd == hz.id_rs2);

    // Load result only exists in WB, so a dependent in ID waits one cycle
    assign load_use = hz.ex_mem_ren && hz.ex_rd != 5'd0 && (rs1_hit || rs2_hit);

    assign hz.flush_front = hz.redirect;
    assign hz.stall_front = load_use && !hz.redirect;   // Redirect wins

    // After one bubble the load has left EX
    single_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        hz.stall_front |=> !hz.stall_front)
        else $error("front end stalled two cycles in a row");

endmodule

`default_nettype wire

//--- source/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module pipeline_core (
    input  wire         clk,
    input  wire         rst_n,
    output logic [63:0] fetch_pc,
    input  wire  [31:0] fetch_instr,
    output logic        commit_valid,
    output logic [63:0] commit_pc,
    output logic [4:0]  commit_rd,
    output logic        commit_wen,
    output logic [63:0] commit_data
);
    import rv_pkg::*;

    logic [63:0] pc;

    logic        if_id_valid;
    logic [63:0] if_id_pc;
    logic [31:0] if_id_instr;
    dec_t        id_dec;
    logic [63:0] id_rdata_a;
    logic [63:0] id_rdata_b;

    logic        id_ex_valid;
    logic [63:0] id_ex_pc;
    dec_t        id_ex_dec;
    logic [63:0] id_ex_rs1;
    logic [63:0] id_ex_rs2;

    logic [63:0] ex_rs1_fwd;
    logic [63:0] ex_rs2_fwd;
    logic [63:0] ex_op_b;
    logic [63:0] ex_alu_res;
    logic [63:0] ex_target;
    logic        ex_taken;

    logic        ex_mem_valid;
    logic [63:0] ex_mem_pc;
    logic [63:0] ex_mem_res;
    logic [63:0] ex_mem_sdata;
    logic [4:0]  ex_mem_rd;
    logic        ex_mem_reg_wen;
    logic        ex_mem_ren;
    logic        ex_mem_wen;

    logic        mem_wb_valid;
    logic [63:0] mem_wb_pc;
    logic [63:0] mem_wb_res;
    logic [4:0]  mem_wb_rd;
    logic        mem_wb_reg_wen;
    logic        mem_wb_ren;
    logic [63:0] dmem_rdata;
    logic [63:0] wb_data;

    hazard_if hz ();

    // Youngest producer wins and x0 is never forwarded
    function automatic logic [63:0] fwd_operand(input logic [4:0]  src,
                                                input logic [63:0] stage_val);
        if (src == 5'd0)
            return stage_val;
        if (ex_mem_valid && ex_mem_reg_wen && ex_mem_rd == src)
            return ex_mem_res;
        if (mem_wb_valid && mem_wb_reg_wen && mem_wb_rd == src)
            return wb_data;
        return stage_val;
    endfunction

    assign fetch_pc = pc;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= `RV_RESET_PC;
        else if (hz.flush_front)
            pc <= ex_target;
        else if (!hz.stall_front)
            pc <= pc + 64'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            if_id_valid <= 1'b0;
        else if (hz.flush_front)
            if_id_valid <= 1'b0;
        else if (!hz.stall_front)
            if_id_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!hz.stall_front) begin
            if_id_pc    <= pc;
            if_id_instr <= fetch_instr;
        end
    end

    inst_decode u_decode (
        .instr (if_id_instr),
        .dec   (id_dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra      (id_dec.rs1),
        .rb      (id_dec.rs2),
        .rw      (mem_wb_rd),
        .wen     (mem_wb_valid && mem_wb_reg_wen),
        .wdata   (wb_data),
        .rdata_a (id_rdata_a),
        .rdata_b (id_rdata_b)
    );

    assign hz.id_rs1     = if_id_valid ? id_dec.rs1 : 5'd0;
    assign hz.id_rs2     = if_id_valid ? id_dec.rs2 : 5'd0;
    assign hz.ex_rd      = id_ex_dec.rd;
    assign hz.ex_mem_ren = id_ex_valid && id_ex_dec.mem_ren;
    assign hz.redirect   = id_ex_valid && (id_ex_dec.is_jal || ex_taken);

    hazard_ctrl u_hazard (
        .clk   (clk),
        .rst_n (rst_n),
        .hz    (hz.ctrl_mp)
    );

    // Stall or flush leaves a bubble in ID/EX
    always_ff @(posedge clk) begin
        if (!rst_n)
            id_ex_valid <= 1'b0;
        else
            id_ex_valid <= if_id_valid && !hz.stall_front && !hz.flush_front;
    end

    always_ff @(posedge clk) begin
        id_ex_pc  <= if_id_pc;
        id_ex_dec <= id_dec;
        id_ex_rs1 <= id_rdata_a;
        id_ex_rs2 <= id_rdata_b;
    end

    always_comb begin
        ex_rs1_fwd = fwd_operand(id_ex_dec.rs1, id_ex_rs1);
        ex_rs2_fwd = fwd_operand(id_ex_dec.rs2, id_ex_rs2);
    end

    assign ex_op_b   = id_ex_dec.use_imm ? id_ex_dec.imm : ex_rs2_fwd;
    assign ex_taken  = id_ex_dec.is_branch && ex_alu_res[0];
    assign ex_target = id_ex_pc + id_ex_dec.imm;     // Branch and JAL share it

    exec_alu u_alu (
        .op     (id_ex_dec.alu_op),
        .a      (ex_rs1_fwd),
        .b      (ex_op_b),
        .result (ex_alu_res)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_mem_valid <= 1'b0;
        else
            ex_mem_valid <= id_ex_valid;
    end

    always_ff @(posedge clk) begin
        ex_mem_pc      <= id_ex_pc;
        ex_mem_res     <= id_ex_dec.is_jal ? id_ex_pc + 64'd4 : ex_alu_res;  // Link value
        ex_mem_sdata   <= ex_rs2_fwd;
        ex_mem_rd      <= id_ex_dec.rd;
        ex_mem_reg_wen <= id_ex_dec.reg_wen;
        ex_mem_ren     <= id_ex_dec.mem_ren;
        ex_mem_wen     <= id_ex_dec.mem_wen;
    end

    data_sram u_dmem (
        .clk   (clk),
        .rst_n (rst_n),
        .ren   (ex_mem_valid && ex_mem_ren),
        .wen   (ex_mem_valid && ex_mem_wen),
        .addr  (ex_mem_res),
        .wdata (ex_mem_sdata),
        .rdata (dmem_rdata)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            mem_wb_valid <= 1'b0;
        else
            mem_wb_valid <= ex_mem_valid;
    end

    always_ff @(posedge clk) begin
        mem_wb_pc      <= ex_mem_pc;
        mem_wb_res     <= ex_mem_res;
        mem_wb_rd      <= ex_mem_rd;
        mem_wb_reg_wen <= ex_mem_reg_wen;
        mem_wb_ren     <= ex_mem_ren;
    end

    assign wb_data = mem_wb_ren ? dmem_rdata : mem_wb_res;

    assign commit_valid = mem_wb_valid;
    assign commit_pc    = mem_wb_pc;
    assign commit_rd    = mem_wb_rd;
    assign commit_wen   = mem_wb_reg_wen;
    assign commit_data  = wb_data;

    commit_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> commit_pc[1:0] == 2'b00)
        else $error("misaligned commit pc %h", commit_pc);

endmodule

`default_nettype wire

//--- testbench/tb_pipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_params.svh"

module tb_pipeline;

    localparam int rom_words    = 128;     // Indexed by fetch_pc[8:2]
    localparam int max_len      = 100;
    localparam int num_tests    = 10;
    localparam int reset_cycles = 5;
    localparam int gap_limit    = 20;      // Longest quiet stretch between two commits
    localparam int watchdog_cycles =
        num_tests * (20 * max_len + reset_cycles + 2) + 100;

    typedef enum int {
        k_add, k_sub, k_and, k_or, k_addi, k_ld, k_sd, k_beq, k_bne, k_jal
    } kind_t;

    logic        clk;
    logic        rst_n;
    logic [63:0] fetch_pc;
    logic [31:0] fetch_instr;
    logic        commit_valid;
    logic [63:0] commit_pc;
    logic [4:0]  commit_rd;
    logic        commit_wen;
    logic [63:0] commit_data;

    int seed = 4;
    int n_pass;
    int n_fail;
    int test_err;

    // Program image plus the fields it was built from
    logic [31:0] rom   [rom_words];
    kind_t       p_kind [rom_words];
    logic [4:0]  p_rd   [rom_words];
    logic [4:0]  p_rs1  [rom_words];
    logic [4:0]  p_rs2  [rom_words];
    logic [63:0] p_imm  [rom_words];
    int          p_len;

    logic [63:0] exp_pc   [$];
    logic        exp_wen  [$];
    logic [4:0]  exp_rd   [$];
    logic [63:0] exp_data [$];

    pipeline_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_pc     (fetch_pc),
        .fetch_instr  (fetch_instr),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_rd    (commit_rd),
        .commit_wen   (commit_wen),
        .commit_data  (commit_data)
    );

    assign fetch_instr = rom[fetch_pc[8:2]];   // Same-cycle instruction return

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic int rand_between(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic string mode_name(input int mode);
        case (mode)
            0:       return "alu";
            1:       return "forwarding";
            2:       return "memory";
            3:       return "control";
            default: return "mixed";
        endcase
    endfunction

    function automatic kind_t choose_kind(input int mode);
        int r;
        r = rand_between(0, 9);
        case (mode)
            0, 1:    return kind_t'(r % 5);
            2:       return (r < 3) ? k_ld : (r < 6) ? k_sd : (r < 8) ? k_addi : k_add;
            3:       return (r < 2) ? k_beq : (r < 4) ? k_bne : (r < 5) ? k_jal :
                            (r < 7) ? k_addi : k_sub;
            default: return kind_t'(r);
        endcase
    endfunction

    task automatic fill_program(input int mode);
        int          reg_hi;
        int          slots;
        int          imm;
        int          tgt;
        kind_t       k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        reg_hi = (mode == 0) ? 15 : (mode == 2) ? 4 : (mode == 4) ? 5 : 3;
        slots  = (mode == 2) ? 4 : 16;
        p_len  = rand_between(20, max_len);
        for (int i = 0; i < p_len - 1; i++) begin
            k   = choose_kind(mode);
            rd  = 5'(rand_between(mode == 0 ? 0 : 1, reg_hi));
            rs1 = 5'(rand_between(0, reg_hi));
            rs2 = 5'(rand_between(0, reg_hi));
            imm = (mode == 3) ? rand_between(-2, 2) : rand_between(-2048, 2047);
            tgt = i + rand_between(1, 4);
            if (tgt > p_len - 1)
                tgt = p_len - 1;             // Never past the final self-jump
            case (k)
                k_add:  rom[i] <= r_type(7'h00, rs2, rs1, 3'b000, rd);
                k_sub:  rom[i] <= r_type(7'h20, rs2, rs1, 3'b000, rd);
                k_and:  rom[i] <= r_type(7'h00, rs2, rs1, 3'b111, rd);
                k_or:   rom[i] <= r_type(7'h00, rs2, rs1, 3'b110, rd);
                k_addi: rom[i] <= i_type(12'(imm), rs1, 3'b000, rd, 7'b0010011);
                k_ld: begin
                    rs1    = 5'd0;
                    imm    = rand_between(0, slots - 1) * 8;
                    rom[i] <= i_type(12'(imm), rs1, 3'b011, rd, 7'b0000011);
                end
                k_sd: begin
                    rs1    = 5'd0;
                    imm    = rand_between(0, slots - 1) * 8;
                    rom[i] <= s_type(12'(imm), rs2, rs1);
                end
                k_beq, k_bne: begin
                    imm    = (tgt - i) * 4;
                    rom[i] <= b_type(13'(imm), rs2, rs1, (k == k_bne) ? 3'b001 : 3'b000);
                end
                default: begin
                    imm    = (tgt - i) * 4;
                    rom[i] <= j_type(21'(imm), rd);
                end
            endcase
            p_kind[i] = k;
            p_rd[i]   = rd;
            p_rs1[i]  = rs1;
            p_rs2[i]  = rs2;
            p_imm[i]  = imm;
        end
        // Program ends in a jump to itself
        rom[p_len - 1]    <= j_type(21'd0, 5'd0);
        p_kind[p_len - 1] = k_jal;
        p_rd[p_len - 1]   = 5'd0;
        p_rs1[p_len - 1]  = 5'd0;
        p_rs2[p_len - 1]  = 5'd0;
        p_imm[p_len - 1]  = 64'd0;
        for (int i = p_len; i < rom_words; i++)
            rom[i] <= i_type(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);   // ADDI x0 filler
    endtask

    // ISA-level model stepping one instruction at a time
    task automatic build_expected();
        logic [63:0] regs [`RV_NREGS];
        logic [63:0] dmem [`RV_DMEM_WORDS];
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] res;
        logic [63:0] addr;
        logic [63:0] pc;
        logic        wen;
        int          idx;
        int          next;
        exp_pc.delete();
        exp_wen.delete();
        exp_rd.delete();
        exp_data.delete();
        for (int i = 0; i < `RV_NREGS; i++)
            regs[i] = 64'd0;
        for (int i = 0; i < `RV_DMEM_WORDS; i++)
            dmem[i] = 64'd0;
        idx = 0;
        while (idx < p_len) begin
            pc   = `RV_RESET_PC + 64'(idx) * 4;
            a    = regs[p_rs1[idx]];
            b    = regs[p_rs2[idx]];
            addr = a + p_imm[idx];
            next = idx + 1;
            wen  = 1'b1;
            res  = 64'd0;
            case (p_kind[idx])
                k_add:  res = a + b;
                k_sub:  res = a - b;
                k_and:  res = a & b;
                k_or:   res = a | b;
                k_addi: res = addr;
                k_ld:   res = dmem[(addr >> 3) % `RV_DMEM_WORDS];
                k_sd: begin
                    dmem[(addr >> 3) % `RV_DMEM_WORDS] = b;
                    wen = 1'b0;
                end
                k_beq, k_bne: begin
                    wen = 1'b0;
                    if ((a == b) == (p_kind[idx] == k_beq))
                        next = idx + int'(p_imm[idx] >> 2);
                end
                default: begin
                    res  = pc + 64'd4;
                    next = idx + int'(p_imm[idx] >> 2);
                end
            endcase
            wen = wen && p_rd[idx] != 5'd0;   // x0 stays zero
            if (wen)
                regs[p_rd[idx]] = res;
            exp_pc.push_back(pc);
            exp_wen.push_back(wen);
            exp_rd.push_back(p_rd[idx]);
            exp_data.push_back(res);
            if (idx == p_len - 1)
                break;
            idx = next;
        end
    endtask

    task automatic compare_commit(input int i);
        assert (commit_pc === exp_pc[i]) else begin
            $display("ERR commit_pc #%0d expected %h actual %h", i, exp_pc[i], commit_pc);
            test_err++;
        end
        assert (commit_wen === exp_wen[i]) else begin
            $display("ERR commit_wen #%0d expected %h actual %h", i, exp_wen[i], commit_wen);
            test_err++;
        end
        if (exp_wen[i]) begin
            assert (commit_rd === exp_rd[i]) else begin
                $display("ERR commit_rd #%0d expected %h actual %h", i, exp_rd[i], commit_rd);
                test_err++;
            end
            assert (commit_data === exp_data[i]) else begin
                $display("ERR commit_data #%0d expected %h actual %h",
                         i, exp_data[i], commit_data);
                test_err++;
            end
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        assert (commit_valid === 1'b0) else begin
            $display("ERR commit_valid expected 0 actual %h", commit_valid);
            test_err++;
        end
        assert (fetch_pc === `RV_RESET_PC) else begin
            $display("ERR fetch_pc expected %h actual %h", `RV_RESET_PC, fetch_pc);
            test_err++;
        end
    endtask

    task automatic check_commits(output int got);
        int idle;
        got  = 0;
        idle = 0;
        while (got < exp_pc.size() && idle < gap_limit) begin
            @(negedge clk);
            if (commit_valid) begin
                compare_commit(got);
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    task automatic run_test(input int num, input int mode);
        int got;
        test_err = 0;
        @(posedge clk);
        rst_n <= 1'b0;
        fill_program(mode);
        build_expected();
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        check_commits(got);
        assert (got == exp_pc.size()) else begin
            $display("Test %0d stopped after %0d of %0d commits, no commit for %0d cycles",
                     num, got, exp_pc.size(), gap_limit);
            test_err++;
        end
        if (test_err == 0)
            n_pass++;
        else
            n_fail++;
        $display("Test %0d %s: %0d of %0d commits, %0d errors, %s",
                 num, mode_name(mode), got, exp_pc.size(), test_err,
                 (test_err == 0) ? "ok" : "bad");
    endtask

    initial begin
        rst_n  = 1'b0;
        n_pass = 0;
        n_fail = 0;
        for (int i = 0; i < rom_words; i++)
            rom[i] = i_type(12'(i), 5'd0, 3'b000, 5'd0, 7'b0010011);
        for (int t = 0; t < num_tests; t++)
            run_test(t, t % 5);
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog ran out after %0d cycles and the tests had not finished",
                 watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/rv_pkg.sv
source/hazard_if.sv
source/inst_decode.sv
source/reg_file.sv
source/exec_alu.sv
source/data_sram.sv
source/hazard_ctrl.sv
source/pipeline_core.sv
testbench/tb_pipeline.sv
